// ==== include/tb_vectors.svh ====
/*
 * Stimulus and expected-report table for the debug-entry monitor testbench.
 * Included inside the testbench module; load_vectors() fills the row queue.
 * Row flags hold {pc_bad, cause_bad, dpc_bad, overflow}.
 */

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam logic [31:0] NOP_OPCODE = 32'h0000_0013;

// What the loop does after driving a row
localparam logic [2:0] CHK_NONE   = 3'd0;
localparam logic [2:0] CHK_REPORT = 3'd1;
localparam logic [2:0] CHK_HOLD   = 3'd2;
localparam logic [2:0] CHK_QUIET  = 3'd3;
localparam logic [2:0] CHK_DRAIN  = 3'd4;

typedef struct packed {
  int          test;
  logic        last;
  retire_rec_t rec;
  logic        req;
  logic        fen;
  logic [2:0]  chk;
  int          ack_dly;
  logic [3:0]  flags;
  logic [31:0] exp_pc;
} vec_row_t;

vec_row_t rows[$];
int       test_no;

// ------------------------------
// Record builders
// ------------------------------
function automatic retire_rec_t run_rec(input logic [31:0] pc_r, input logic [31:0] pc_w,
                                        input logic [31:0] insn);
  retire_rec_t r;
  r = '0;
  r.valid    = 1'b1;
  r.insn     = insn;
  r.pc_rdata = pc_r;
  r.pc_wdata = pc_w;
  return r;
endfunction

// Debug record with an optional interrupt taken on entry
function automatic retire_rec_t dbg_rec(input logic [31:0] pc, input dbg_cause_e cause,
                                        input logic [31:0] dpc, input logic intr,
                                        input logic [10:0] icause, input logic [31:0] mtvec);
  retire_rec_t r;
  r = run_rec(pc, pc + 32'd4, NOP_OPCODE);
  r.dbg_mode   = 1'b1;
  r.dbg_cause  = cause;
  r.dpc        = dpc;
  r.intr       = intr;
  r.intr_cause = icause;
  r.mtvec      = mtvec;
  return r;
endfunction

function automatic retire_rec_t dbg_plain(input logic [31:0] pc, input dbg_cause_e cause,
                                          input logic [31:0] dpc);
  return dbg_rec(pc, cause, dpc, 1'b0, 11'h0, 32'h0);
endfunction

// ------------------------------
// Table building
// ------------------------------
function automatic void add(input retire_rec_t rec, input logic req, input logic [2:0] chk,
                            input int ack, input logic [3:0] flags, input logic [31:0] pc);
  vec_row_t w;
  w.test    = test_no;
  w.last    = 1'b0;
  w.rec     = rec;
  w.req     = req;
  w.fen     = 1'b1;
  w.chk     = chk;
  w.ack_dly = ack;
  w.flags   = flags;
  w.exp_pc  = pc;
  rows.push_back(w);
endfunction

function automatic void step(input retire_rec_t rec);
  add(rec, 1'b0, CHK_NONE, 0, 4'h0, 32'h0);
endfunction

// Idle slot with a halt request pulse
function automatic void halt_req();
  add('0, 1'b1, CHK_NONE, 0, 4'h0, 32'h0);
endfunction

// dret back out of debug followed by one normal record
function automatic void leave_dbg(input logic [31:0] pc);
  retire_rec_t r;
  r = run_rec(32'h808, 32'h80C, DRET_OPCODE);
  r.dbg_mode = 1'b1;
  step(r);
  step(run_rec(pc, pc + 32'd4, NOP_OPCODE));
endfunction

function automatic void end_test();
  vec_row_t w;
  w = rows.pop_back();
  w.last = 1'b1;
  rows.push_back(w);
endfunction

function automatic void load_vectors();
  // Quiet trace after reset while fetch enable captures 0x800
  test_no = 1;
  step(run_rec(32'h100, 32'h104, NOP_OPCODE));
  step(run_rec(32'h104, 32'h108, NOP_OPCODE));
  add('0, 1'b0, CHK_QUIET, 0, 4'h0, 32'h0);
  end_test();
  // Halt request entries with a clean report and then a wrong pc and cause
  test_no = 2;
  step(run_rec(32'h200, 32'h204, NOP_OPCODE));
  halt_req();
  add(dbg_plain(32'h800, CAUSE_HALTREQ, 32'h204), 1'b0, CHK_REPORT, 2, 4'h0, 32'h800);
  leave_dbg(32'h204);
  halt_req();
  add(dbg_plain(32'h804, CAUSE_STEP, 32'h208), 1'b0, CHK_REPORT, 3, 4'hC, 32'h804);
  leave_dbg(32'h208);
  end_test();
  // Ebreak and c.ebreak entries report the breakpoint pc as dpc
  test_no = 3;
  step(run_rec(32'h400, 32'h404, EBREAK_OPCODE));
  add(dbg_plain(32'h800, CAUSE_EBREAK, 32'h400), 1'b0, CHK_REPORT, 2, 4'h0, 32'h800);
  leave_dbg(32'h404);
  step(run_rec(32'h500, 32'h504, EBREAK_OPCODE));
  add(dbg_plain(32'h800, CAUSE_EBREAK, 32'h504), 1'b0, CHK_REPORT, 1, 4'h2, 32'h800);
  leave_dbg(32'h504);
  step(run_rec(32'h600, 32'h602, CEBREAK_OPCODE));
  add(dbg_plain(32'h800, CAUSE_EBREAK, 32'h600), 1'b0, CHK_REPORT, 2, 4'h0, 32'h800);
  leave_dbg(32'h602);
  end_test();
  // Interrupt taken on the entry record with trap base 0x1000
  test_no = 4;
  step(run_rec(32'h700, 32'h704, NOP_OPCODE));
  halt_req();
  add(dbg_rec(32'h800, CAUSE_HALTREQ, 32'h101C, 1'b1, 11'h007, 32'h1001),
      1'b0, CHK_REPORT, 2, 4'h0, 32'h800);
  leave_dbg(32'h704);
  halt_req();
  add(dbg_rec(32'h800, CAUSE_HALTREQ, 32'h103C, 1'b1, 11'h407, 32'h1001),
      1'b0, CHK_REPORT, 2, 4'h0, 32'h800);
  leave_dbg(32'h708);
  halt_req();
  // Direct mode wants the bare base
  add(dbg_rec(32'h800, CAUSE_HALTREQ, 32'h1000, 1'b1, 11'h007, 32'h1000),
      1'b0, CHK_REPORT, 2, 4'h0, 32'h800);
  leave_dbg(32'h70C);
  halt_req();
  // Plain retirement dpc is wrong once the entry takes an interrupt
  add(dbg_rec(32'h800, CAUSE_HALTREQ, 32'h710, 1'b1, 11'h007, 32'h1001),
      1'b0, CHK_REPORT, 2, 4'h2, 32'h800);
  leave_dbg(32'h710);
  end_test();
  // Second entry of the back-pressure test lands while ack is held
  test_no = 5;
  step(run_rec(32'h900, 32'h904, NOP_OPCODE));
  halt_req();
  add(dbg_plain(32'h800, CAUSE_HALTREQ, 32'h904), 1'b0, CHK_HOLD, 30, 4'h0, 32'h800);
  leave_dbg(32'h904);
  halt_req();
  step(dbg_plain(32'h800, CAUSE_HALTREQ, 32'h908));
  add('0, 1'b0, CHK_DRAIN, 0, 4'h0, 32'h0);
  add('0, 1'b0, CHK_QUIET, 0, 4'h0, 32'h0);
  leave_dbg(32'h908);
  halt_req();
  add(dbg_plain(32'h800, CAUSE_HALTREQ, 32'h90C), 1'b0, CHK_REPORT, 2, 4'h1, 32'h800);
  leave_dbg(32'h90C);
  halt_req();
  add(dbg_plain(32'h800, CAUSE_HALTREQ, 32'h910), 1'b0, CHK_REPORT, 2, 4'h0, 32'h800);
  leave_dbg(32'h910);
  end_test();
  // Report timing with an idle port and a fast ack
  test_no = 6;
  step(run_rec(32'hA00, 32'hA04, NOP_OPCODE));
  halt_req();
  add(dbg_plain(32'h800, CAUSE_HALTREQ, 32'hA04), 1'b0, CHK_REPORT, 1, 4'h0, 32'h800);
  leave_dbg(32'hA04);
  end_test();
endfunction

`endif

// ==== dv/tb_dbg_mon.sv ====
/*
 * Testbench for the debug-entry monitor. Walks the vector table one row
 * per cycle, answers the report port with a delayed ack and checks each
 * report against the table, then prints a per-test line and a summary.
 */

`timescale 1ns/1ps

module tb_dbg_mon
  import dbg_mon_pkg::*;
();

  logic            cov_assert_if;
  logic            reset_i;
  retire_rec_t     trace_i;
  logic            debug_req_i;
  logic            fetch_enable_i;
  logic [XLEN-1:0] dm_halt_addr_i;
  report_t         report_o;
  logic            report_req_o;
  logic            report_ack_i;

  int errs;
  int ack_dly;
  int tests_run;
  int tests_failed;
  int errs_at_test;

  `include "tb_vectors.svh"

  dbg_mon_top i_dbg_mon_top (
    .cov_assert_if  (cov_assert_if),
    .reset_i        (reset_i),
    .trace_i        (trace_i),
    .debug_req_i    (debug_req_i),
    .fetch_enable_i (fetch_enable_i),
    .dm_halt_addr_i (dm_halt_addr_i),
    .report_o       (report_o),
    .report_req_o   (report_req_o),
    .report_ack_i   (report_ack_i)
  );

  // 8 ns clock
  initial begin
    cov_assert_if = 1'b0;
    forever #4 cov_assert_if = ~cov_assert_if;
  end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  task automatic drive_idle();
    trace_i     = '0;
    debug_req_i = 1'b0;
  endtask

  // Wait for req, measure its delay from the sampling edge, compare payload
  task automatic check_report(input vec_row_t row);
    int cyc;
    cyc = 0;
    @(posedge cov_assert_if);
    @(negedge cov_assert_if);
    drive_idle();
    while (!report_req_o && cyc < 20) begin
      @(posedge cov_assert_if);
      cyc++;
      @(negedge cov_assert_if);
      drive_idle();
    end
    assert (report_req_o) else begin
      $display("test %0d: report request never came", row.test);
      errs++;
    end
    if (report_req_o) begin
      assert (cyc == 4) else begin
        $display("ERR report_req_o delay got %h exp %h", cyc, 4);
        errs++;
      end
      assert (report_o.verdict.pc == row.exp_pc) else begin
        $display("ERR report_o.verdict.pc got %h exp %h", report_o.verdict.pc, row.exp_pc);
        errs++;
      end
      assert (report_o.verdict.pc_bad == row.flags[3]) else begin
        $display("ERR report_o.verdict.pc_bad got %h exp %h",
                 report_o.verdict.pc_bad, row.flags[3]);
        errs++;
      end
      assert (report_o.verdict.cause_bad == row.flags[2]) else begin
        $display("ERR report_o.verdict.cause_bad got %h exp %h",
                 report_o.verdict.cause_bad, row.flags[2]);
        errs++;
      end
      assert (report_o.verdict.dpc_bad == row.flags[1]) else begin
        $display("ERR report_o.verdict.dpc_bad got %h exp %h",
                 report_o.verdict.dpc_bad, row.flags[1]);
        errs++;
      end
      assert (report_o.overflow == row.flags[0]) else begin
        $display("ERR report_o.overflow got %h exp %h", report_o.overflow, row.flags[0]);
        errs++;
      end
    end
  endtask

  // Port back to idle, req and ack both low
  task automatic wait_port_idle();
    int n;
    n = 0;
    while ((report_req_o || report_ack_i) && n < 64) begin
      @(negedge cov_assert_if);
      drive_idle();
      n++;
    end
    assert (!report_req_o && !report_ack_i) else begin
      $display("report handshake did not complete within %0d cycles", n);
      errs++;
    end
  endtask

  // No report may show up over this window
  task automatic watch_quiet();
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < 16; n++) begin
      @(negedge cov_assert_if);
      drive_idle();
      if (report_req_o) begin
        seen = 1'b1;
      end
    end
    assert (!seen) else begin
      $display("a report was raised with no debug entry pending");
      errs++;
    end
  endtask

  // ------------------------------
  // Ack responder
  // ------------------------------
  initial begin
    int d;
    int n;
    report_ack_i = 1'b0;
    forever begin
      @(negedge cov_assert_if);
      if (report_req_o && !report_ack_i) begin
        d = ack_dly;
        for (int k = 0; k < d; k++) begin
          @(negedge cov_assert_if);
        end
        report_ack_i = 1'b1;
        n = 0;
        while (report_req_o && n < 16) begin
          @(negedge cov_assert_if);
          n++;
        end
        assert (!report_req_o) else begin
          $display("report request stayed high after ack");
          errs++;
        end
        report_ack_i = 1'b0;
      end
    end
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    reset_i        = 1'b1;
    trace_i        = '0;
    debug_req_i    = 1'b0;
    fetch_enable_i = 1'b0;
    dm_halt_addr_i = 32'h0000_0800;
    errs           = 0;
    ack_dly        = 2;
    tests_run      = 0;
    tests_failed   = 0;
    errs_at_test   = 0;
    load_vectors();
    repeat (4) @(posedge cov_assert_if);
    @(negedge cov_assert_if);
    reset_i = 1'b0;
    assert (!report_req_o) else begin
      $display("ERR report_req_o got %h exp %h after reset", report_req_o, 1'b0);
      errs++;
    end
    foreach (rows[i]) begin
      @(negedge cov_assert_if);
      trace_i        = rows[i].rec;
      debug_req_i    = rows[i].req;
      fetch_enable_i = rows[i].fen;
      if (rows[i].chk == CHK_REPORT || rows[i].chk == CHK_HOLD) begin
        ack_dly = rows[i].ack_dly;
        check_report(rows[i]);
        if (rows[i].chk == CHK_REPORT) begin
          wait_port_idle();
        end
      end else if (rows[i].chk == CHK_QUIET) begin
        watch_quiet();
      end else if (rows[i].chk == CHK_DRAIN) begin
        wait_port_idle();
      end
      if (rows[i].last) begin
        tests_run++;
        if (errs != errs_at_test) begin
          tests_failed++;
        end
        $display("test %0d %s, %0d errors", rows[i].test,
                 (errs != errs_at_test) ? "failed" : "ok", errs - errs_at_test);
        errs_at_test = errs;
      end
    end
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errs);
    if (errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/cause_tracker.sv ====
/*
 * Stage 2a. Follows the trace and the halt request line to work out
 * which dcsr.cause the next debug entry should report, and latches
 * the debug halt address when fetch is first enabled.
 */

`timescale 1ns/1ps

module cause_tracker
  import dbg_mon_pkg::*;
(
  input  logic            cov_assert_if,
  input  logic            reset_i,
  input  classified_t     cls_i,
  input  logic            debug_req_i,
  input  logic            fetch_enable_i,
  input  logic [XLEN-1:0] dm_halt_addr_i,
  output dbg_cause_e      exp_cause_o,
  output logic [XLEN-1:0] halt_addr_o
);

  dbg_cause_e cause_q;
  dbg_cause_e cause_d;
  logic       is_brk;
  logic       fetch_seen_q;
  logic       first_fetch;

  // ------------------------------
  // Expected cause
  // ------------------------------
  assign is_brk = cls_i.rec.valid &&
                  ((cls_i.kind == INSN_EBREAK) || (cls_i.kind == INSN_CEBREAK));

  // Priority haltreq > ebreak > step, dret clears
  always_comb begin
    cause_d = cause_q;
    if (debug_req_i) begin
      cause_d = CAUSE_HALTREQ;
    end else if (is_brk) begin
      cause_d = CAUSE_EBREAK;
    end else if (cls_i.rec.valid && cls_i.rec.dcsr_step) begin
      cause_d = CAUSE_STEP;
    end else if (cls_i.rec.valid && (cls_i.kind == INSN_DRET)) begin
      cause_d = CAUSE_NONE;
    end
  end

  // Output carries the state left by earlier records,
  // so it lines up with the record now in cls_i
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      cause_q     <= CAUSE_NONE;
      exp_cause_o <= CAUSE_NONE;
    end else begin
      cause_q     <= cause_d;
      exp_cause_o <= cause_q;
    end
  end

  // ------------------------------
  // Halt address capture
  // ------------------------------
  assign first_fetch = fetch_enable_i && !fetch_seen_q;

  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      fetch_seen_q <= 1'b0;
      halt_addr_o  <= '0;
    end else if (first_fetch) begin
      fetch_seen_q <= 1'b1;
      // Word aligned
      halt_addr_o  <= {dm_halt_addr_i[XLEN-1:2], 2'b00};
    end
  end

  // Once latched the halt address must hold for the whole run
  a_halt_addr_frozen: assert property (
    @(posedge cov_assert_if) disable iff (reset_i)
    fetch_seen_q |=> $stable(halt_addr_o)
  ) else $error("halt_addr_o changed after capture: %08h", halt_addr_o);

endmodule

// ==== logic/dbg_mon_pkg.sv ====
/*
 * Shared types and constants for the debug-entry monitor.
 * Every monitor stage imports this package for its record formats,
 * instruction encodings and trap-vector constants.
 */

package dbg_mon_pkg;

  // ------------------------------
  // Widths and encodings
  // ------------------------------
  localparam int unsigned XLEN    = 32;
  localparam int unsigned CAUSE_W = 11;

  // Full instruction words as seen on the retirement trace
  localparam logic [31:0] EBREAK_OPCODE  = 32'h0010_0073;
  localparam logic [31:0] CEBREAK_OPCODE = 32'h0000_9002;
  localparam logic [31:0] DRET_OPCODE    = 32'h7B20_0073;

  // Bit 10 of the interrupt cause marks an NMI (0x400)
  localparam int unsigned NMI_CAUSE_BIT = 10;
  localparam logic [XLEN-1:0] NMI_VECTOR_OFFSET = 32'h0000_003C;
  localparam logic [1:0] MTVEC_MODE_VECTORED = 2'd1;

  // ------------------------------
  // Enums
  // ------------------------------
  // dcsr.cause encoding
  typedef enum logic [2:0] {
    CAUSE_NONE    = 3'd0,
    CAUSE_EBREAK  = 3'd1,
    CAUSE_TRIGGER = 3'd2,
    CAUSE_HALTREQ = 3'd3,
    CAUSE_STEP    = 3'd4
  } dbg_cause_e;

  typedef enum logic [1:0] {
    INSN_OTHER,
    INSN_EBREAK,
    INSN_CEBREAK,
    INSN_DRET
  } insn_kind_e;

  // Report port handshake phases
  typedef enum logic [1:0] {
    RP_IDLE,
    RP_REQ,
    RP_RELEASE
  } rp_state_e;

  // ------------------------------
  // Records
  // ------------------------------
  // One retirement record from the core trace
  typedef struct packed {
    logic               valid;
    logic [31:0]        insn;
    logic [XLEN-1:0]    pc_rdata;
    logic [XLEN-1:0]    pc_wdata;
    logic               dbg_mode;
    dbg_cause_e         dbg_cause;
    logic               intr;
    logic [CAUSE_W-1:0] intr_cause;
    logic [XLEN-1:0]    dpc;
    logic [XLEN-1:0]    mtvec;
    logic               dcsr_step;
  } retire_rec_t;

  typedef struct packed {
    retire_rec_t rec;
    insn_kind_e  kind;
    logic        first_dbg;
  } classified_t;

  // What the next debug entry must look like
  typedef struct packed {
    dbg_cause_e      exp_cause;
    logic [XLEN-1:0] halt_addr;
    logic [XLEN-1:0] pred_dpc;
  } expect_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic            pc_bad;
    logic            cause_bad;
    logic            dpc_bad;
  } verdict_t;

  typedef struct packed {
    verdict_t verdict;
    logic     overflow;
  } report_t;

endpackage

// ==== logic/dbg_mon_top.sv ====
/*
 * Debug-entry monitor top level. Connect the core retirement trace and
 * debug inputs; one verdict per debug entry comes out on the report port.
 */

`timescale 1ns/1ps

module dbg_mon_top
  import dbg_mon_pkg::*;
(
  input  logic            cov_assert_if,
  input  logic            reset_i,
  input  retire_rec_t     trace_i,
  input  logic            debug_req_i,
  input  logic            fetch_enable_i,
  input  logic [XLEN-1:0] dm_halt_addr_i,
  output report_t         report_o,
  output logic            report_req_o,
  input  logic            report_ack_i
);

  classified_t cls;
  expect_t     exp;
  verdict_t    verdict;
  logic        verdict_valid;

  // Stage 1
  insn_classify i_insn_classify (
    .cov_assert_if (cov_assert_if),
    .reset_i       (reset_i),
    .trace_i       (trace_i),
    .cls_o         (cls)
  );

  // Stage 2, both halves fill one expect_t
  cause_tracker i_cause_tracker (
    .cov_assert_if  (cov_assert_if),
    .reset_i        (reset_i),
    .cls_i          (cls),
    .debug_req_i    (debug_req_i),
    .fetch_enable_i (fetch_enable_i),
    .dm_halt_addr_i (dm_halt_addr_i),
    .exp_cause_o    (exp.exp_cause),
    .halt_addr_o    (exp.halt_addr)
  );

  dpc_predictor i_dpc_predictor (
    .cov_assert_if (cov_assert_if),
    .reset_i       (reset_i),
    .cls_i         (cls),
    .pred_dpc_o    (exp.pred_dpc)
  );

  // Stage 3
  entry_checker i_entry_checker (
    .cov_assert_if   (cov_assert_if),
    .reset_i         (reset_i),
    .cls_i           (cls),
    .exp_i           (exp),
    .verdict_o       (verdict),
    .verdict_valid_o (verdict_valid)
  );

  report_port i_report_port (
    .cov_assert_if   (cov_assert_if),
    .reset_i         (reset_i),
    .verdict_i       (verdict),
    .verdict_valid_i (verdict_valid),
    .report_o        (report_o),
    .report_req_o    (report_req_o),
    .report_ack_i    (report_ack_i)
  );

endmodule

// ==== logic/dpc_predictor.sv ====
/*
 * Stage 2b. Predicts the dpc a debug entry must report. Plain
 * retirement predicts the next pc, ebreak predicts its own pc, and a
 * record with an interrupt predicts the CLINT trap vector.
 */

`timescale 1ns/1ps

module dpc_predictor
  import dbg_mon_pkg::*;
(
  input  logic            cov_assert_if,
  input  logic            reset_i,
  input  classified_t     cls_i,
  output logic [XLEN-1:0] pred_dpc_o
);

  logic [XLEN-1:0]    pred_q;
  logic [XLEN-1:0]    base;
  logic [XLEN-1:0]    cause_off;
  logic [XLEN-1:0]    vec_addr;
  logic [CAUSE_W-1:0] cause_idx;
  logic               is_nmi;
  logic               is_brk;
  logic               take_intr;

  assign is_brk = (cls_i.kind == INSN_EBREAK) || (cls_i.kind == INSN_CEBREAK);
  assign take_intr = cls_i.rec.valid && cls_i.rec.intr;

  // ------------------------------
  // Trap vector
  // ------------------------------
  // mtvec base with mode bits dropped
  assign base   = {cls_i.rec.mtvec[XLEN-1:2], 2'b00};
  assign is_nmi = cls_i.rec.intr_cause[NMI_CAUSE_BIT];

  // Cause number without the NMI marker
  always_comb begin
    cause_idx = cls_i.rec.intr_cause;
    cause_idx[NMI_CAUSE_BIT] = 1'b0;
  end

  // Four bytes per vector slot
  assign cause_off = {{(XLEN-CAUSE_W-2){1'b0}}, cause_idx, 2'b00};

  always_comb begin
    vec_addr = base;
    if (cls_i.rec.mtvec[1:0] == MTVEC_MODE_VECTORED) begin
      if (is_nmi) begin
        vec_addr = base + NMI_VECTOR_OFFSET;
      end else begin
        vec_addr = base + cause_off;
      end
    end
  end

  // ------------------------------
  // Prediction state
  // ------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      pred_q     <= '0;
      pred_dpc_o <= '0;
    end else begin
      // Interrupt on the current record wins, otherwise history
      pred_dpc_o <= take_intr ? vec_addr : pred_q;
      if (take_intr) begin
        pred_q <= vec_addr;
      end else if (cls_i.rec.valid && !cls_i.rec.dbg_mode) begin
        pred_q <= is_brk ? cls_i.rec.pc_rdata : cls_i.rec.pc_wdata;
      end
    end
  end

endmodule

// ==== logic/entry_checker.sv ====
/*
 * Stage 3. Holds each record for one cycle so it meets the stage 2
 * expectations, then grades a first debug record on pc, cause and dpc.
 * A graded entry leaves as a single-cycle verdict pulse.
 */

`timescale 1ns/1ps

module entry_checker
  import dbg_mon_pkg::*;
(
  input  logic        cov_assert_if,
  input  logic        reset_i,
  input  classified_t cls_i,
  input  expect_t     exp_i,
  output verdict_t    verdict_o,
  output logic        verdict_valid_o
);

  classified_t ent_q;
  logic        ent_vld_q;
  logic        cause_bad;

  // Alignment with the parallel stage 2 outputs
  always_ff @(posedge cov_assert_if) begin
    ent_q <= cls_i;
  end

  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      ent_vld_q       <= 1'b0;
      verdict_valid_o <= 1'b0;
    end else begin
      ent_vld_q       <= cls_i.first_dbg;
      verdict_valid_o <= ent_vld_q;
    end
  end

  // Trigger entries are reported but not graded on cause
  assign cause_bad = (ent_q.rec.dbg_cause != CAUSE_TRIGGER) &&
                     (ent_q.rec.dbg_cause != exp_i.exp_cause);

  // Verdict payload
  always_ff @(posedge cov_assert_if) begin
    if (ent_vld_q) begin
      verdict_o.pc        <= ent_q.rec.pc_rdata;
      verdict_o.pc_bad    <= ent_q.rec.pc_rdata != exp_i.halt_addr;
      verdict_o.cause_bad <= cause_bad;
      // Prediction already holds the trap vector on an intr entry
      verdict_o.dpc_bad   <= ent_q.rec.dpc != exp_i.pred_dpc;
    end
  end

  // Two entries back to back would need a debug record with no
  // history flag, which stage 1 never produces
  a_verdict_pulse: assert property (
    @(posedge cov_assert_if) disable iff (reset_i)
    verdict_valid_o |=> !verdict_valid_o
  ) else $error("verdict_valid_o high on consecutive cycles");

endmodule

// ==== logic/insn_classify.sv ====
/*
 * Stage 1 of the monitor. Samples the trace every cycle, then decodes
 * the instruction kind and flags the first record of a debug entry.
 */

`timescale 1ns/1ps

module insn_classify
  import dbg_mon_pkg::*;
(
  input  logic        cov_assert_if,
  input  logic        reset_i,
  input  retire_rec_t trace_i,
  output classified_t cls_o
);

  retire_rec_t rec_q;
  insn_kind_e  kind;
  logic        in_dbg_q;
  logic        first_dbg;

  // Sampling register, only valid is control state
  always_ff @(posedge cov_assert_if) begin
    rec_q <= trace_i;
    if (reset_i) begin
      rec_q.valid <= 1'b0;
    end
  end

  // Exact match on the full instruction word
  always_comb begin
    kind = INSN_OTHER;
    if (rec_q.insn == EBREAK_OPCODE) begin
      kind = INSN_EBREAK;
    end else if (rec_q.insn == CEBREAK_OPCODE) begin
      kind = INSN_CEBREAK;
    end else if (rec_q.insn == DRET_OPCODE) begin
      kind = INSN_DRET;
    end
  end

  // Debug mode of the last valid record
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      in_dbg_q <= 1'b0;
    end else if (rec_q.valid) begin
      in_dbg_q <= rec_q.dbg_mode;
    end
  end

  // Entry edge: in debug now, previous valid record was not
  assign first_dbg = rec_q.valid && rec_q.dbg_mode && !in_dbg_q;

  always_ff @(posedge cov_assert_if) begin
    cls_o.rec  <= rec_q;
    cls_o.kind <= kind;
    if (reset_i) begin
      cls_o.rec.valid <= 1'b0;
      cls_o.first_dbg <= 1'b0;
    end else begin
      cls_o.first_dbg <= first_dbg;
    end
  end

endmodule

// ==== logic/report_port.sv ====
/*
 * Output side of the monitor. Takes one verdict at a time and offers it
 * on a four-phase req/ack port. Verdicts arriving while busy are lost
 * and the next accepted report carries overflow.
 */

`timescale 1ns/1ps

module report_port
  import dbg_mon_pkg::*;
(
  input  logic     cov_assert_if,
  input  logic     reset_i,
  input  verdict_t verdict_i,
  input  logic     verdict_valid_i,
  output report_t  report_o,
  output logic     report_req_o,
  input  logic     report_ack_i
);

  rp_state_e state_q;
  logic      drop_q;
  logic      accept;

  assign accept = verdict_valid_i && (state_q == RP_IDLE);

  // ------------------------------
  // Handshake FSM
  // ------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      state_q <= RP_IDLE;
      drop_q  <= 1'b0;
    end else begin
      case (state_q)
        RP_IDLE: begin
          if (verdict_valid_i) begin
            state_q <= RP_REQ;
          end
        end
        // Wait for ack high, then drop req
        RP_REQ: begin
          if (report_ack_i) begin
            state_q <= RP_RELEASE;
          end
        end
        // Busy until ack returns low
        RP_RELEASE: begin
          if (!report_ack_i) begin
            state_q <= RP_IDLE;
          end
        end
        default: state_q <= RP_IDLE;
      endcase
      // Sticky until handed out with an accepted report
      if (accept) begin
        drop_q <= 1'b0;
      end else if (verdict_valid_i) begin
        drop_q <= 1'b1;
      end
    end
  end

  // Payload loads only when idle
  always_ff @(posedge cov_assert_if) begin
    if (accept) begin
      report_o.verdict  <= verdict_i;
      report_o.overflow <= drop_q;
    end
  end

  assign report_req_o = (state_q == RP_REQ);

  a_report_stable: assert property (
    @(posedge cov_assert_if) disable iff (reset_i)
    report_req_o && $past(report_req_o) |-> $stable(report_o)
  ) else $error("report_o changed under req: %h", report_o);

  a_req_fall_after_ack: assert property (
    @(posedge cov_assert_if) disable iff (reset_i)
    $fell(report_req_o) |-> $past(report_ack_i)
  ) else $error("report_req_o fell without report_ack_i");

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it once
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_dbg_mon -o sim_tb || exit 1
out="$(./obj_dir/sim_tb)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1

// ==== sim.f ====
+incdir+include
logic/dbg_mon_pkg.sv
logic/insn_classify.sv
logic/cause_tracker.sv
logic/dpc_predictor.sv
logic/entry_checker.sv
logic/report_port.sv
logic/dbg_mon_top.sv
dv/tb_dbg_mon.sv
